// ==== Bender.yml ====
package:
  name: mem_exec_unit

sources:
  - files:
      - rtl/mem_unit_pkg.sv
      - rtl/tx_byte_timer.sv
      - rtl/apb_data_ram.sv
      - rtl/uart_tx_port.sv
      - rtl/apb_addr_decode.sv
      - rtl/mem_access_fsm.sv
      - rtl/mem_exec_unit.sv
  - target: test
    files:
      - tests/tb_mem_exec_unit.sv

// ==== rtl/apb_addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_addr_decode
	import mem_unit_pkg::*;
(
	input wire apb_req_t i_req,
	output apb_req_t o_ram_req,
	output apb_req_t o_uart_req,
	output apb_rsp_t o_rsp,
	input wire apb_rsp_t i_ram_rsp,
	input wire apb_rsp_t i_uart_rsp
);

	logic ram_hit;
	logic uart_hit;

	// ram window, upper bits against the base
	assign ram_hit = (i_req.paddr[XLEN-1:RAM_ADDR_W+2] == RAM_BASE[XLEN-1:RAM_ADDR_W+2]);

	// uart owns two exact words
	assign uart_hit = (i_req.paddr == UART_DATA_ADDR) || (i_req.paddr == UART_STATUS_ADDR);

	// request fans out, psel only to the hit
	always_comb begin
		o_ram_req = i_req;
		o_ram_req.psel = i_req.psel && ram_hit;
		o_uart_req = i_req;
		o_uart_req.psel = i_req.psel && uart_hit;
	end

	// response mux
	always_comb begin
		if (ram_hit) begin
			o_rsp = i_ram_rsp;
		end else if (uart_hit) begin
			o_rsp = i_uart_rsp;
		end else begin
			// unmapped, answer here with an error
			o_rsp.pready = i_req.psel && i_req.penable;
			o_rsp.pslverr = i_req.psel && i_req.penable;
			o_rsp.prdata = '0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/apb_data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_data_ram
	import mem_unit_pkg::*;
(
	input wire logic clk,
	input wire apb_req_t i_req,
	output apb_rsp_t o_rsp
);

	// word storage
	logic [XLEN-1:0] mem [2**RAM_ADDR_W];

	// word index, byte offset dropped
	logic [RAM_ADDR_W-1:0] word_idx;
	logic wr_en;

	assign word_idx = i_req.paddr[RAM_ADDR_W+1:2];

	// write only in the access phase
	assign wr_en = i_req.psel && i_req.penable && i_req.pwrite;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[word_idx] <= i_req.pwdata;
		end
	end

	// combinational read
	assign o_rsp.prdata = mem[word_idx];
	// zero wait states
	assign o_rsp.pready = 1'b1;
	// never faults
	assign o_rsp.pslverr = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/mem_access_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm
	import mem_unit_pkg::*;
(
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_issue_valid,
	input wire ld_st_entry_t i_issue,
	input wire retire_store_t i_retire,
	input wire apb_rsp_t i_apb_rsp,
	output logic o_issue_ready,
	output logic o_retire_done,
	output cdb_bus_t o_cdb,
	output apb_req_t o_apb_req
);

	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

	state_t state;
	logic ready_q;
	logic psel_q, penable_q, pwrite_q;
	logic [XLEN-1:0] paddr_q, pwdata_q;
	// load context for the cdb entry
	logic [TAG_W-1:0] tag_q;
	logic wb_q;
	logic cdb_valid_q, cdb_exc_q;
	logic [TAG_W-1:0] cdb_tag_q;
	logic [XLEN-1:0] cdb_result_q, cdb_store_q;
	logic retire_done_q;
	logic [XLEN-1:0] eff_addr;
	logic retire_pend, issue_fire, access_done;

	assign eff_addr = i_issue.rs1_data + i_issue.immediate;
	// retire still high during its own done pulse
	assign retire_pend = i_retire.store_ready && !retire_done_q;
	assign o_issue_ready = ready_q && !retire_pend;
	assign issue_fire = i_issue_valid && o_issue_ready;
	assign access_done = (state == ACCESS) && i_apb_rsp.pready;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= IDLE;
			ready_q <= 1'b0;
			psel_q <= 1'b0;
			penable_q <= 1'b0;
			cdb_valid_q <= 1'b0;
			retire_done_q <= 1'b0;
		end else begin
			cdb_valid_q <= 1'b0;
			retire_done_q <= 1'b0;
			case (state)
				IDLE: begin
					ready_q <= 1'b1;
					// retire write first, then loads need the bus
					if (retire_pend || (issue_fire && !i_issue.is_store)) begin
						state <= SETUP;
						psel_q <= 1'b1;
						ready_q <= 1'b0;
					end else if (issue_fire) begin
						// store goes straight to the cdb
						cdb_valid_q <= 1'b1;
					end
				end
				SETUP: begin
					penable_q <= 1'b1;
					state <= ACCESS;
				end
				ACCESS: begin
					// wait states keep us here
					if (i_apb_rsp.pready) begin
						psel_q <= 1'b0;
						penable_q <= 1'b0;
						ready_q <= 1'b1;
						state <= IDLE;
						if (pwrite_q) begin
							retire_done_q <= 1'b1;
						end else if (wb_q) begin
							cdb_valid_q <= 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// bus and cdb payload
	always_ff @(posedge clk) begin
		if (state == IDLE && retire_pend) begin
			pwrite_q <= 1'b1;
			paddr_q <= i_retire.mem_address;
			pwdata_q <= i_retire.rs2_data;
		end else if (state == IDLE && issue_fire) begin
			pwrite_q <= 1'b0;
			paddr_q <= eff_addr;
			pwdata_q <= '0;
			tag_q <= i_issue.rd_tag;
			wb_q <= i_issue.wb_valid;
			// store entry, overwritten later for a load
			cdb_tag_q <= i_issue.rd_tag;
			cdb_result_q <= eff_addr;
			cdb_store_q <= i_issue.rs2_data;
			cdb_exc_q <= 1'b0;
		end else if (access_done && !pwrite_q) begin
			cdb_tag_q <= tag_q;
			// zero result on a bus error
			cdb_result_q <= i_apb_rsp.pslverr ? '0 : i_apb_rsp.prdata;
			cdb_store_q <= '0;
			cdb_exc_q <= i_apb_rsp.pslverr;
		end
	end

	assign o_retire_done = retire_done_q;

	assign o_apb_req = '{psel: psel_q, penable: penable_q, pwrite: pwrite_q,
		paddr: paddr_q, pwdata: pwdata_q};

	assign o_cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, result: cdb_result_q,
		store_data: cdb_store_q, exception: cdb_exc_q};

endmodule

`default_nettype wire

// ==== rtl/mem_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_exec_unit
	import mem_unit_pkg::*;
(
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_issue_valid,
	input wire ld_st_entry_t i_issue,
	input wire retire_store_t i_retire,
	output logic o_issue_ready,
	output logic o_retire_done,
	output cdb_bus_t o_cdb,
	output logic [7:0] o_tx_byte,
	output logic o_tx_start
);

	// master side
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	// slave side
	apb_req_t ram_req;
	apb_req_t uart_req;
	apb_rsp_t ram_rsp;
	apb_rsp_t uart_rsp;

	// arbitration and apb master
	mem_access_fsm i_mem_access_fsm (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_issue_valid (i_issue_valid),
		.i_issue       (i_issue),
		.i_retire      (i_retire),
		.i_apb_rsp     (apb_rsp),
		.o_issue_ready (o_issue_ready),
		.o_retire_done (o_retire_done),
		.o_cdb         (o_cdb),
		.o_apb_req     (apb_req)
	);

	// address map
	apb_addr_decode i_apb_addr_decode (
		.i_req      (apb_req),
		.o_ram_req  (ram_req),
		.o_uart_req (uart_req),
		.o_rsp      (apb_rsp),
		.i_ram_rsp  (ram_rsp),
		.i_uart_rsp (uart_rsp)
	);

	apb_data_ram i_apb_data_ram (
		.clk   (clk),
		.i_req (ram_req),
		.o_rsp (ram_rsp)
	);

	// uart tx, byte and start leave the block
	uart_tx_port i_uart_tx_port (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_req      (uart_req),
		.o_rsp      (uart_rsp),
		.o_tx_byte  (o_tx_byte),
		.o_tx_start (o_tx_start)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_unit_pkg.sv ====
`default_nettype none

package mem_unit_pkg;

	// datapath and tag widths
	localparam int XLEN = 32;
	localparam int TAG_W = 6;

	// data ram, 128 words
	localparam int RAM_ADDR_W = 7;
	localparam logic [XLEN-1:0] RAM_BASE = 32'h0000_0000;

	// uart register map
	localparam logic [XLEN-1:0] UART_DATA_ADDR = 32'h0000_1000;
	localparam logic [XLEN-1:0] UART_STATUS_ADDR = 32'h0000_1004;

	// busy time in clocks after each tx start
	localparam int unsigned UART_BYTE_CYCLES = 10;
	// wide enough to hold UART_BYTE_CYCLES
	localparam int unsigned TIMER_W = $clog2(UART_BYTE_CYCLES + 1);

	// entry from the issue stage
	typedef struct packed {
		// 0 = load, 1 = store
		logic is_store;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] immediate;
		logic [TAG_W-1:0] rd_tag;
		logic wb_valid;
	} ld_st_entry_t;

	// store presented by the retire stage
	typedef struct packed {
		logic store_ready;
		logic [XLEN-1:0] mem_address;
		logic [XLEN-1:0] rs2_data;
	} retire_store_t;

	// common data bus entry
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic exception;
	} cdb_bus_t;

	// apb master to slave
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [XLEN-1:0] paddr;
		logic [XLEN-1:0] pwdata;
	} apb_req_t;

	// apb slave to master
	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [XLEN-1:0] prdata;
	} apb_rsp_t;

	// status view, busy flag in bit 0
	typedef struct packed {
		logic [XLEN-2:0] rsvd;
		logic busy;
	} uart_status_t;

	// raw data view, last tx byte in the low byte
	typedef struct packed {
		logic [XLEN-9:0] rsvd;
		logic [7:0] tx_byte;
	} uart_data_t;

	// one uart read word, two decodings
	typedef union packed {
		uart_status_t status;
		uart_data_t data;
	} uart_word_u;

endpackage

`default_nettype wire

// ==== rtl/tx_byte_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_byte_timer
	import mem_unit_pkg::*;
(
	input wire logic clk,
	input wire logic i_rst,
	input wire logic i_start,
	output logic o_busy
);

	// remaining byte time in clocks
	logic [TIMER_W-1:0] count;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			count <= '0;
		end else if (i_start) begin
			// reload on every start
			count <= TIMER_W'(UART_BYTE_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// busy until the counter drains
	assign o_busy = (count != '0);

endmodule

`default_nettype wire

// ==== rtl/uart_tx_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx_port
	import mem_unit_pkg::*;
(
	input wire logic clk,
	input wire logic i_rst,
	input wire apb_req_t i_req,
	output apb_rsp_t o_rsp,
	output logic [7:0] o_tx_byte,
	output logic o_tx_start
);

	logic busy;
	logic is_status;
	logic wr_data;
	logic tx_fire;
	logic [7:0] tx_byte_q;
	logic tx_start_q;
	uart_word_u rd_word;

	// byte time counter
	tx_byte_timer i_tx_byte_timer (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_start (tx_fire),
		.o_busy  (busy)
	);

	assign is_status = (i_req.paddr == UART_STATUS_ADDR);

	// data write in the access phase
	assign wr_data = i_req.psel && i_req.penable && i_req.pwrite && !is_status;
	// accepted only once the previous byte is out
	assign tx_fire = wr_data && !busy;

	// start pulse and byte
	always_ff @(posedge clk) begin
		if (i_rst) begin
			tx_start_q <= 1'b0;
		end else begin
			tx_start_q <= tx_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (tx_fire) begin
			tx_byte_q <= i_req.pwdata[7:0];
		end
	end

	// read word, status or data view
	always_comb begin
		rd_word = '0;
		if (is_status) begin
			rd_word.status.busy = busy;
		end else begin
			rd_word.data.tx_byte = tx_byte_q;
		end
	end

	// wait states while a byte is still going out
	assign o_rsp.pready = !(wr_data && busy);
	assign o_rsp.pslverr = 1'b0;
	assign o_rsp.prdata = rd_word;

	assign o_tx_byte = tx_byte_q;
	assign o_tx_start = tx_start_q;

endmodule

`default_nettype wire

// ==== tests/mem_exec_trace.txt ====
# op rs1 rs2 imm tag wb exp_result exp_store exp_exc exp_tx exp_byte, all hex
# ST store issue, RT retire store (rs1 address, rs2 data), LD load, SL uart status load
ST 00000100 cafef00d 00000010 05 1 00000110 cafef00d 0 0 00
RT 00000040 12345678 00000000 00 0 00000000 00000000 0 0 00
LD 00000030 00000000 00000010 0a 1 12345678 00000000 0 0 00
RT 000001fc a5a5c3c3 00000000 00 0 00000000 00000000 0 0 00
LD 000001f0 00000000 0000000c 11 1 a5a5c3c3 00000000 0 0 00
LD 00000040 00000000 00000000 12 0 00000000 00000000 0 0 00
RT 00001000 00000041 00000000 00 0 00000000 00000000 0 1 41
SL 00001000 00000000 00000004 13 1 00000001 00000000 0 0 00
RT 00001000 000002a5 00000000 00 0 00000000 00000000 0 1 a5
SL 00001000 00000000 00000004 14 1 00000001 00000000 0 0 00
LD 00002000 00000000 00000000 15 1 00000000 00000000 1 0 00
LD 00001000 00000000 00000008 16 1 00000000 00000000 1 0 00
ST fffffff0 0badbeef 00000020 3f 1 00000010 0badbeef 0 0 00
LD 00000000 00000000 00000040 20 1 12345678 00000000 0 0 00

// ==== tests/tb_mem_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_exec_unit
	import mem_unit_pkg::*;
();

	// inputs change this long after the rising edge
	localparam int DRIVE_DLY = 2;
	localparam int READY_TIMEOUT = 20;
	localparam int LOAD_TIMEOUT = 20;
	localparam int RETIRE_TIMEOUT = 40;
	// cycles a load without writeback is watched
	localparam int QUIET_WINDOW = 8;

	logic clk;
	logic i_rst;
	logic i_issue_valid;
	ld_st_entry_t i_issue;
	retire_store_t i_retire;
	logic o_issue_ready;
	logic o_retire_done;
	cdb_bus_t o_cdb;
	logic [7:0] o_tx_byte;
	logic o_tx_start;

	// tx start bookkeeping
	int cycle_cnt = 0;
	int tx_count = 0;
	int last_tx_cycle = 0;
	logic [7:0] last_tx_byte = '0;

	mem_exec_unit i_mem_exec_unit (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_issue_valid (i_issue_valid),
		.i_issue       (i_issue),
		.i_retire      (i_retire),
		.o_issue_ready (o_issue_ready),
		.o_retire_done (o_retire_done),
		.o_cdb         (o_cdb),
		.o_tx_byte     (o_tx_byte),
		.o_tx_start    (o_tx_start)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] actual,
		input logic [XLEN-1:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			abort_run("value mismatch");
		end
	endtask

	// one clock, then the drive point
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
		if (o_tx_start === 1'b1) begin
			// a new byte only after the full byte time
			if (tx_count > 0 && cycle_cnt - last_tx_cycle < int'(UART_BYTE_CYCLES)) begin
				abort_run($sformatf("tx_start pulses only %0d cycles apart",
					cycle_cnt - last_tx_cycle));
			end
			tx_count++;
			last_tx_cycle = cycle_cnt;
			last_tx_byte = o_tx_byte;
		end
	endtask

	task automatic check_quiet();
		check_value("o_cdb.valid", o_cdb.valid, 1'b0);
		check_value("o_retire_done", o_retire_done, 1'b0);
		check_value("o_tx_start", o_tx_start, 1'b0);
	endtask

	task automatic reset_dut();
		int waited;
		waited = 0;
		i_rst = 1'b1;
		repeat (5) begin
			next_cycle();
			check_value("o_issue_ready", o_issue_ready, 1'b0);
			check_quiet();
		end
		i_rst = 1'b0;
		// ready comes back on its own
		while (o_issue_ready !== 1'b1) begin
			if (waited >= READY_TIMEOUT) begin
				abort_run("timeout waiting for o_issue_ready after reset");
			end
			next_cycle();
			check_quiet();
			waited++;
		end
	endtask

	// returns one cycle after the accepting edge
	task automatic issue_entry(input ld_st_entry_t ent);
		int waited;
		waited = 0;
		i_issue = ent;
		i_issue_valid = 1'b1;
		// ready depends on the retire input just driven
		#1;
		while (o_issue_ready !== 1'b1) begin
			if (waited >= READY_TIMEOUT) begin
				abort_run("timeout waiting for o_issue_ready to accept an entry");
			end
			next_cycle();
			waited++;
		end
		next_cycle();
		i_issue_valid = 1'b0;
		i_issue = '0;
	endtask

	task automatic run_store_issue(input ld_st_entry_t ent, input logic [XLEN-1:0] exp_res,
		input logic [XLEN-1:0] exp_sd);
		issue_entry(ent);
		// single pulse right after acceptance
		check_value("o_cdb.valid", o_cdb.valid, 1'b1);
		check_value("o_cdb.tag", o_cdb.tag, ent.rd_tag);
		check_value("o_cdb.result", o_cdb.result, exp_res);
		check_value("o_cdb.store_data", o_cdb.store_data, exp_sd);
		check_value("o_cdb.exception", o_cdb.exception, 1'b0);
		next_cycle();
		check_value("o_cdb.valid", o_cdb.valid, 1'b0);
	endtask

	task automatic run_load(input ld_st_entry_t ent, input logic [XLEN-1:0] exp_res,
		input logic exp_exc);
		int waited;
		waited = 0;
		issue_entry(ent);
		if (ent.wb_valid) begin
			while (o_cdb.valid !== 1'b1) begin
				if (waited >= LOAD_TIMEOUT) begin
					abort_run("timeout waiting for o_cdb.valid on a load");
				end
				next_cycle();
				waited++;
			end
			check_value("o_cdb.tag", o_cdb.tag, ent.rd_tag);
			check_value("o_cdb.result", o_cdb.result, exp_res);
			check_value("o_cdb.exception", o_cdb.exception, exp_exc);
		end else begin
			// no writeback, bus must stay silent
			repeat (QUIET_WINDOW) begin
				if (o_cdb.valid === 1'b1) begin
					abort_run("CDB pulse from a load without writeback");
				end
				next_cycle();
			end
			check_value("o_issue_ready", o_issue_ready, 1'b1);
		end
	endtask

	task automatic run_retire(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
		input logic exp_tx, input logic [7:0] exp_byte);
		int waited;
		int tx_before;
		waited = 0;
		tx_before = tx_count;
		i_retire = '{store_ready: 1'b1, mem_address: addr, rs2_data: data};
		// held until the done pulse
		while (o_retire_done !== 1'b1) begin
			if (waited >= RETIRE_TIMEOUT) begin
				abort_run("timeout waiting for o_retire_done");
			end
			next_cycle();
			waited++;
		end
		i_retire = '0;
		check_value("tx_start count", tx_count - tx_before, exp_tx);
		if (exp_tx) begin
			check_value("o_tx_byte", last_tx_byte, exp_byte);
		end
	endtask

	initial begin
		int fd;
		int code;
		int ops_run;
		logic done;
		logic [31:0] op;
		logic [8*128-1:0] skip_line;
		logic [XLEN-1:0] rs1, rs2, imm, exp_res, exp_sd;
		logic [31:0] f_tag, f_wb, f_exc, f_tx, f_byte;
		ld_st_entry_t ent;
		uart_word_u exp_word;

		i_rst = 1'b1;
		i_issue_valid = 1'b0;
		i_issue = '0;
		i_retire = '0;
		ops_run = 0;
		done = 1'b0;

		fd = $fopen("tests/mem_exec_trace.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open tests/mem_exec_trace.txt");
		end

		reset_dut();

		while (!done) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				code = $fgets(skip_line, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", rs1, rs2, imm,
					f_tag, f_wb, exp_res, exp_sd, f_exc, f_tx, f_byte);
				if (code != 10) begin
					abort_run("malformed line in trace file");
				end
				ent = '0;
				ent.is_store = (op == "ST");
				ent.rs1_data = rs1;
				ent.rs2_data = rs2;
				ent.immediate = imm;
				ent.rd_tag = f_tag[TAG_W-1:0];
				ent.wb_valid = f_wb[0];
				if (op == "ST") begin
					run_store_issue(ent, exp_res, exp_sd);
				end else if (op == "RT") begin
					run_retire(rs1, rs2, f_tx[0], f_byte[7:0]);
				end else if (op == "LD") begin
					run_load(ent, exp_res, f_exc[0]);
				end else if (op == "SL") begin
					// expected status word through the union
					exp_word = '0;
					exp_word.status.busy = exp_res[0];
					run_load(ent, exp_word, 1'b0);
				end else begin
					abort_run("unknown operation in trace file");
				end
				ops_run++;
			end
		end
		$fclose(fd);

		if (ops_run > 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("trace file held no operations");
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/mem_unit_pkg.sv
rtl/tx_byte_timer.sv
rtl/apb_data_ram.sv
rtl/uart_tx_port.sv
rtl/apb_addr_decode.sv
rtl/mem_access_fsm.sv
rtl/mem_exec_unit.sv
tests/tb_mem_exec_unit.sv
